// ==== hw/sys_pkg.sv ====
`default_nettype none

package sys_pkg;

    localparam int xlen = 32;

    // Privilege levels
    localparam logic [1:0] priv_user       = 2'd0;
    localparam logic [1:0] priv_supervisor = 2'd1;
    localparam logic [1:0] priv_machine    = 2'd3;

    // Machine CSR addresses
    localparam logic [11:0] csr_mstatus  = 12'h300;
    localparam logic [11:0] csr_mtvec    = 12'h305;
    localparam logic [11:0] csr_mscratch = 12'h340;
    localparam logic [11:0] csr_mepc     = 12'h341;
    localparam logic [11:0] csr_mcause   = 12'h342;

    // Exception codes written to mcause
    localparam logic [3:0] exc_illegal_instr  = 4'd2;
    localparam logic [3:0] exc_breakpoint     = 4'd3;
    localparam logic [3:0] exc_env_call_umode = 4'd8;
    localparam logic [3:0] exc_env_call_smode = 4'd9;
    localparam logic [3:0] exc_env_call_mmode = 4'd11;

    localparam logic [2:0] f3_priv = 3'b000;        // ECALL, EBREAK, xRET, WFI, SFENCE.VMA
    localparam logic [2:0] f3_hlsv = 3'b100;        // Hypervisor load/store
    localparam logic [1:0] csr_op_rw = 2'b01;       // Low funct3 bits of Zicsr ops
    localparam logic [1:0] csr_op_rs = 2'b10;
    localparam logic [1:0] csr_op_rc = 2'b11;

    localparam logic [6:0] funct7_sfence_vma = 7'b0001001;
    localparam logic [6:0] funct7_mret       = 7'b0011000;
    localparam logic [4:0] rs2_xret          = 5'b00010;

    // mstatus bit positions
    localparam int mstatus_mie  = 3;
    localparam int mstatus_mpie = 7;
    localparam int mstatus_mpp  = 11;               // Low bit of the MPP pair
    localparam logic [xlen-1:0] mstatus_wmask = 32'h0000_1888; // MIE, MPIE, MPP

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        logic [2:0]      funct3;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [6:0]      funct7;
        logic [11:0]     imm12;
        logic [xlen-1:0] rs1_data;
    } sys_instr_t;

    typedef struct packed {
        logic            valid;
        logic [11:0]     addr;
        logic [2:0]      funct3;
        logic [4:0]      rd;
        logic [4:0]      uimm;
        logic [xlen-1:0] rs1_data;
    } csr_req_t;

    typedef struct packed {
        logic            exception;
        logic [3:0]      cause;
        logic [xlen-1:0] result;
    } csr_rsp_t;

    typedef struct packed {
        logic            exception;
        logic [3:0]      cause;
        logic            is_xret;
        logic [xlen-1:0] result;
        logic [xlen-1:0] pc;
    } sys_result_t;

    typedef struct packed {
        logic            will_do_xret;
        logic [xlen-1:0] new_mstatus;
        logic [1:0]      new_priv;
    } xret_update_t;

endpackage

`default_nettype wire

// ==== hw/exec_system.sv ====
`default_nettype none

module exec_system (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           instr_valid,
    input  sys_pkg::sys_instr_t            instr,
    input  logic [1:0]                     priv_mode,
    input  logic [sys_pkg::xlen-1:0]       mstatus,
    input  logic [sys_pkg::xlen-1:0]       mepc,
    output sys_pkg::csr_req_t              csr_req,
    input  sys_pkg::csr_rsp_t              csr_rsp,
    output sys_pkg::xret_update_t          xret_update,
    output logic                           result_valid,
    output sys_pkg::sys_result_t           result
);

    logic                 is_csr;
    logic                 is_mret;
    logic [1:0]           xret_level;
    sys_pkg::sys_result_t result_d;

    assign xret_level = instr.funct7[4:3];          // 0 URET, 1 SRET, 3 MRET
    assign is_csr     = instr.funct3 != sys_pkg::f3_priv && instr.funct3 != sys_pkg::f3_hlsv;

    // Zicsr request, answered by csr_file in the same cycle
    assign csr_req.valid    = instr_valid && is_csr;
    assign csr_req.addr     = instr.imm12;
    assign csr_req.funct3   = instr.funct3;
    assign csr_req.rd       = instr.rd;
    assign csr_req.uimm     = instr.rs1;            // rs1 field doubles as uimm
    assign csr_req.rs1_data = instr.rs1_data;

    assign is_mret = instr.funct3 == sys_pkg::f3_priv
                  && instr.rd == 5'd0
                  && instr.rs1 == 5'd0
                  && instr.rs2 == sys_pkg::rs2_xret
                  && instr.funct7 == sys_pkg::funct7_mret;

    // MRET state change, committed at the end of the issue cycle
    always_comb begin
        xret_update.will_do_xret = instr_valid && is_mret && priv_mode == sys_pkg::priv_machine;
        xret_update.new_priv     = mstatus[sys_pkg::mstatus_mpp +: 2];
        xret_update.new_mstatus  = mstatus;
        xret_update.new_mstatus[sys_pkg::mstatus_mie]       = mstatus[sys_pkg::mstatus_mpie];
        xret_update.new_mstatus[sys_pkg::mstatus_mpie]      = 1'b1;
        xret_update.new_mstatus[sys_pkg::mstatus_mpp +: 2]  = sys_pkg::priv_machine;
    end

    always_comb begin
        result_d.exception = 1'b0;
        result_d.cause     = sys_pkg::exc_illegal_instr;
        result_d.is_xret   = 1'b0;
        result_d.result    = '0;
        result_d.pc        = instr.pc;

        if (instr.funct3 == sys_pkg::f3_hlsv) begin
            result_d.exception = 1'b1;              // No hypervisor extension
        end else if (is_csr) begin
            result_d.exception = csr_rsp.exception;
            result_d.cause     = csr_rsp.cause;
            result_d.result    = csr_rsp.result;    // Old CSR value
        end else if (instr.rd != 5'd0) begin
            result_d.exception = 1'b1;
        end else if (instr.funct7 == sys_pkg::funct7_sfence_vma) begin
            result_d.exception = 1'b0;              // No paging, nothing to flush
        end else if (instr.rs1 != 5'd0) begin
            result_d.exception = 1'b1;
        end else begin
            casez ({instr.funct7, instr.rs2})
                {7'b0000000, 5'b00000}: begin       // ECALL
                    result_d.exception = 1'b1;
                    case (priv_mode)
                        sys_pkg::priv_machine:    result_d.cause = sys_pkg::exc_env_call_mmode;
                        sys_pkg::priv_supervisor: result_d.cause = sys_pkg::exc_env_call_smode;
                        sys_pkg::priv_user:       result_d.cause = sys_pkg::exc_env_call_umode;
                        default:                  result_d.cause = sys_pkg::exc_illegal_instr;
                    endcase
                end
                {7'b0000000, 5'b00001}: begin       // EBREAK
                    result_d.exception = 1'b1;
                    result_d.cause     = sys_pkg::exc_breakpoint;
                end
                {7'b00??000, 5'b00010}: begin       // URET, SRET, MRET
                    // A trap outranks the return, so is_xret may ride along with it
                    result_d.is_xret = 1'b1;
                    result_d.result  = mepc;        // Return target
                    if (xret_level == sys_pkg::priv_machine) begin
                        result_d.exception = priv_mode != sys_pkg::priv_machine;
                    end else begin
                        result_d.exception = 1'b1;  // Only MRET exists here
                    end
                end
                {7'b0001000, 5'b00101}: begin       // WFI
                    result_d.exception = 1'b0;      // No interrupts to wait for
                end
                default: begin
                    result_d.exception = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid     <= 1'b0;
            result.exception <= 1'b0;
            result.is_xret   <= 1'b0;
        end else begin
            result_valid     <= instr_valid;
            result.exception <= instr_valid && result_d.exception;
            result.is_xret   <= instr_valid && result_d.is_xret;
            result.cause     <= result_d.cause;
            result.result    <= result_d.result;
            result.pc        <= result_d.pc;
        end
    end

endmodule

`default_nettype wire

// ==== hw/csr_file.sv ====
`default_nettype none

module csr_file (
    input  logic                        clk,
    input  logic                        rst,
    input  sys_pkg::csr_req_t           csr_req,
    output sys_pkg::csr_rsp_t           csr_rsp,
    input  logic [1:0]                  priv_mode,
    input  sys_pkg::xret_update_t       xret_update,
    input  logic                        trap_enter,
    input  logic [3:0]                  trap_cause,
    input  logic [sys_pkg::xlen-1:0]    trap_pc,
    output logic [sys_pkg::xlen-1:0]    mstatus,
    output logic [sys_pkg::xlen-1:0]    mepc,
    output logic [sys_pkg::xlen-1:0]    mtvec
);

    logic [sys_pkg::xlen-1:0] mscratch;
    logic [sys_pkg::xlen-1:0] mcause;
    logic [sys_pkg::xlen-1:0] rdata;
    logic [sys_pkg::xlen-1:0] operand;
    logic [sys_pkg::xlen-1:0] wdata;
    logic                     known;
    logic                     do_write;

    // Read mux that also flags unimplemented addresses
    always_comb begin
        known = 1'b1;
        case (csr_req.addr)
            sys_pkg::csr_mstatus:  rdata = mstatus;
            sys_pkg::csr_mtvec:    rdata = mtvec;
            sys_pkg::csr_mscratch: rdata = mscratch;
            sys_pkg::csr_mepc:     rdata = mepc;
            sys_pkg::csr_mcause:   rdata = mcause;
            default: begin
                rdata = '0;
                known = 1'b0;
            end
        endcase
    end

    // All implemented CSRs are machine level
    assign csr_rsp.exception = csr_req.valid
                            && (!known || priv_mode != sys_pkg::priv_machine);
    assign csr_rsp.cause     = sys_pkg::exc_illegal_instr;
    assign csr_rsp.result    = rdata;

    // funct3[2] selects the immediate forms
    assign operand = csr_req.funct3[2] ? {{(sys_pkg::xlen-5){1'b0}}, csr_req.uimm}
                                       : csr_req.rs1_data;

    always_comb begin
        case (csr_req.funct3[1:0])
            sys_pkg::csr_op_rw: wdata = operand;
            sys_pkg::csr_op_rs: wdata = rdata | operand;
            sys_pkg::csr_op_rc: wdata = rdata & ~operand;
            default:            wdata = rdata;
        endcase
    end

    // Set/clear with a zero source field is a pure read
    assign do_write = csr_req.valid && !csr_rsp.exception
                   && (csr_req.funct3[1:0] == sys_pkg::csr_op_rw || csr_req.uimm != 5'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus  <= '0;                         // MPP = user
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (trap_enter) begin
            mepc   <= {trap_pc[sys_pkg::xlen-1:2], 2'b00};
            mcause <= {{(sys_pkg::xlen-4){1'b0}}, trap_cause};
            mstatus[sys_pkg::mstatus_mpie]     <= mstatus[sys_pkg::mstatus_mie];
            mstatus[sys_pkg::mstatus_mie]      <= 1'b0;
            mstatus[sys_pkg::mstatus_mpp +: 2] <= priv_mode; // Privilege trapped from
        end else if (xret_update.will_do_xret) begin
            mstatus <= xret_update.new_mstatus;
        end else if (do_write) begin
            case (csr_req.addr)
                sys_pkg::csr_mstatus:  mstatus  <= wdata & sys_pkg::mstatus_wmask;
                sys_pkg::csr_mtvec:    mtvec    <= wdata;
                sys_pkg::csr_mscratch: mscratch <= wdata;
                sys_pkg::csr_mepc:     mepc     <= {wdata[sys_pkg::xlen-1:2], 2'b00};
                sys_pkg::csr_mcause:   mcause   <= wdata;
                default: ;                          // do_write implies a known address
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/trap_commit.sv ====
`default_nettype none

module trap_commit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        result_valid,
    input  sys_pkg::sys_result_t        result,
    input  sys_pkg::xret_update_t       xret_update,
    input  logic [sys_pkg::xlen-1:0]    mtvec,
    output logic [1:0]                  priv_mode,
    output logic                        trap_enter,
    output logic [3:0]                  trap_cause,
    output logic [sys_pkg::xlen-1:0]    trap_pc,
    output logic                        redirect_valid,
    output logic [sys_pkg::xlen-1:0]    redirect_pc
);

    logic take_redirect;

    // Trap entry one cycle after issue
    assign trap_enter = result_valid && result.exception;
    assign trap_cause = result.cause;
    assign trap_pc    = result.pc;

    // Exceptions outrank the xRET flag
    assign take_redirect = result_valid && (result.exception || result.is_xret);

    // Current privilege mode
    always_ff @(posedge clk) begin
        if (rst) begin
            priv_mode <= sys_pkg::priv_machine;
        end else if (trap_enter) begin
            priv_mode <= sys_pkg::priv_machine;     // Traps always land in M-mode
        end else if (xret_update.will_do_xret) begin
            priv_mode <= xret_update.new_priv;      // MPP of the old mstatus
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= take_redirect;
            if (result.exception) begin
                redirect_pc <= {mtvec[sys_pkg::xlen-1:2], 2'b00}; // Direct mode only
            end else begin
                redirect_pc <= result.result;       // mepc captured at MRET
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/system_unit.sv ====
`default_nettype none

module system_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        instr_valid,
    input  sys_pkg::sys_instr_t         instr,
    output logic                        result_valid,
    output sys_pkg::sys_result_t        result,
    output logic                        redirect_valid,
    output logic [sys_pkg::xlen-1:0]    redirect_pc,
    output logic [1:0]                  priv_mode
);

    sys_pkg::csr_req_t        csr_req;
    sys_pkg::csr_rsp_t        csr_rsp;
    sys_pkg::xret_update_t    xret_update;
    logic [sys_pkg::xlen-1:0] mstatus;
    logic [sys_pkg::xlen-1:0] mepc;
    logic [sys_pkg::xlen-1:0] mtvec;
    logic                     trap_enter;
    logic [3:0]               trap_cause;
    logic [sys_pkg::xlen-1:0] trap_pc;

    exec_system i_exec_system (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .priv_mode    (priv_mode),
        .mstatus      (mstatus),
        .mepc         (mepc),
        .csr_req      (csr_req),
        .csr_rsp      (csr_rsp),
        .xret_update  (xret_update),
        .result_valid (result_valid),
        .result       (result)
    );

    csr_file i_csr_file (
        .clk          (clk),
        .rst          (rst),
        .csr_req      (csr_req),
        .csr_rsp      (csr_rsp),
        .priv_mode    (priv_mode),
        .xret_update  (xret_update),
        .trap_enter   (trap_enter),
        .trap_cause   (trap_cause),
        .trap_pc      (trap_pc),
        .mstatus      (mstatus),
        .mepc         (mepc),
        .mtvec        (mtvec)
    );

    trap_commit i_trap_commit (
        .clk            (clk),
        .rst            (rst),
        .result_valid   (result_valid),
        .result         (result),
        .xret_update    (xret_update),
        .mtvec          (mtvec),
        .priv_mode      (priv_mode),
        .trap_enter     (trap_enter),
        .trap_cause     (trap_cause),
        .trap_pc        (trap_pc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

// ==== verif/system_unit_props.sv ====
`default_nettype none

module system_unit_props (
    input logic clk,
    input logic rst,
    input logic instr_valid,
    input logic result_valid,
    input logic redirect_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // Every issued instruction gives one result strobe
    assert property (@(posedge clk) disable iff (rst) instr_valid |=> result_valid)
        else $error("result_valid missing one cycle after instr_valid");

    assert property (@(posedge clk) disable iff (rst) result_valid |-> $past(instr_valid))
        else $error("result_valid without an instruction one cycle before");

    assert property (@(posedge clk) disable iff (rst) redirect_valid |-> $past(result_valid))
        else $error("redirect_valid without a result one cycle before");

    // Registers cleared by the first reset edge
    assert property (@(posedge clk) $past(rst) |-> !result_valid && !redirect_valid)
        else $error("result or redirect strobe high during reset");

endmodule

bind system_unit system_unit_props i_props (
    .clk            (clk),
    .rst            (rst),
    .instr_valid    (instr_valid),
    .result_valid   (result_valid),
    .redirect_valid (redirect_valid)
);

`default_nettype wire

// ==== verif/system_unit_tb.sv ====
`default_nettype none

module system_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int timeout_cycles = 20;

    logic                     clk;
    logic                     rst;
    logic                     instr_valid;
    sys_pkg::sys_instr_t      instr;
    logic                     result_valid;
    sys_pkg::sys_result_t     result;
    logic                     redirect_valid;
    logic [sys_pkg::xlen-1:0] redirect_pc;
    logic [1:0]               priv_mode;

    int errors = 0;
    int tests  = 0;

    system_unit i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic compare_result(input sys_pkg::sys_result_t exp,
                                  input sys_pkg::sys_result_t got, input logic check_value);
        if (got.exception !== exp.exception || got.pc !== exp.pc) begin
            $display("Mismatch at %0t: exception %b pc %h, expected %b pc %h", $time,
                     got.exception, got.pc, exp.exception, exp.pc);
            errors++;
        end else if (exp.exception && got.cause !== exp.cause) begin
            $display("Mismatch at %0t: cause %0d, expected %0d", $time, got.cause, exp.cause);
            errors++;
        end else if (!exp.exception && got.is_xret !== exp.is_xret) begin
            $display("Mismatch at %0t: is_xret %b, expected %b", $time, got.is_xret, exp.is_xret);
            errors++;
        end else if (!exp.exception && check_value && got.result !== exp.result) begin
            $display("Mismatch at %0t: old CSR value %h, expected %h", $time,
                     got.result, exp.result);
            errors++;
        end
    endtask

    task automatic compare_redirect(input logic exp_valid, input logic [sys_pkg::xlen-1:0] exp_pc,
                                    input logic got_valid, input logic [sys_pkg::xlen-1:0] got_pc);
        if (got_valid !== exp_valid) begin
            $display("Mismatch at %0t: redirect_valid %b, expected %b", $time, got_valid, exp_valid);
            errors++;
        end else if (exp_valid && got_pc !== exp_pc) begin
            $display("Mismatch at %0t: redirect_pc %h, expected %h", $time, got_pc, exp_pc);
            errors++;
        end
    endtask

    task automatic compare_priv(input logic [1:0] exp, input logic [1:0] got);
        if (got !== exp) begin
            $display("Mismatch at %0t: privilege %0d, expected %0d", $time, got, exp);
            errors++;
        end
    endtask

    initial begin
        int                   fd;
        int                   n;
        int                   cycles;
        int                   errors_before;
        logic                 timed_out;
        logic [8*160-1:0]     line;
        logic [31:0]          pc, rd, f3, rs1, rs2, f7, imm, data;
        logic [31:0]          exc, cause, xret, res, redir, rpc, prv;
        sys_pkg::sys_instr_t  next_instr;
        sys_pkg::sys_result_t exp_res;

        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        timed_out   = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("verif/system_unit_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file verif/system_unit_stim.txt");
            errors++;
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            pc, rd, f3, rs1, rs2, f7, imm, data,
                            exc, cause, xret, res, redir, rpc, prv);
                if (n == 15) begin                      // Comment and blank lines skipped
                    tests++;
                    errors_before       = errors;
                    next_instr.pc       = pc;
                    next_instr.rd       = rd[4:0];
                    next_instr.funct3   = f3[2:0];
                    next_instr.rs1      = rs1[4:0];
                    next_instr.rs2      = rs2[4:0];
                    next_instr.funct7   = f7[6:0];
                    next_instr.imm12    = imm[11:0];
                    next_instr.rs1_data = data;
                    exp_res.exception   = exc[0];
                    exp_res.cause       = cause[3:0];
                    exp_res.is_xret     = xret[0];
                    exp_res.result      = res;
                    exp_res.pc          = pc;

                    @(posedge clk);
                    instr_valid <= 1'b1;
                    instr       <= next_instr;
                    @(posedge clk);
                    instr_valid <= 1'b0;

                    cycles = 0;
                    do begin
                        @(negedge clk);
                        cycles++;
                    end while (!result_valid && cycles < timeout_cycles);
                    if (!result_valid) begin
                        $display("Timeout at %0t: result_valid never rose", $time);
                        errors++;
                        timed_out = 1'b1;
                        break;
                    end
                    // Old value only for Zicsr ops
                    compare_result(exp_res, result, f3[2:0] != 3'd0 && f3[2:0] != 3'd4);

                    if (redir[0]) begin
                        cycles = 0;
                        do begin
                            @(negedge clk);
                            cycles++;
                        end while (!redirect_valid && cycles < timeout_cycles);
                        if (!redirect_valid) begin
                            $display("Timeout at %0t: redirect_valid never rose", $time);
                            errors++;
                            timed_out = 1'b1;
                            break;
                        end
                    end else begin
                        @(negedge clk);                 // Cycle N+2, no redirect due
                    end
                    compare_redirect(redir[0], rpc, redirect_valid, redirect_pc);
                    compare_priv(prv[1:0], priv_mode);  // Trap entry settled by now
                    $display("Test %0d at pc %h %s", tests, pc,
                             errors == errors_before ? "ok" : "with errors");
                end
            end
            $fclose(fd);
        end

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0 && tests > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/system_unit_stim.txt ====
# Columns 1 to 8 hold pc rd funct3 rs1 rs2 funct7 imm12 rs1_data in hex
# Columns 9 to 15 hold the expected exception cause xret result redirect redirect_pc priv
00000100 01 1 05 00 00 305 00000803 0 0 0 00000000 0 00000000 3
00000104 01 1 05 00 00 340 a5a50f0f 0 0 0 00000000 0 00000000 3
00000108 01 2 06 00 00 340 000000f0 0 0 0 a5a50f0f 0 00000000 3
0000010c 01 3 07 00 00 340 a0000001 0 0 0 a5a50fff 0 00000000 3
00000110 01 2 00 00 00 340 ffffffff 0 0 0 05a50ffe 0 00000000 3
00000114 01 7 00 00 00 340 00000000 0 0 0 05a50ffe 0 00000000 3
00000118 01 5 1a 00 00 340 00000000 0 0 0 05a50ffe 0 00000000 3
0000011c 01 2 00 00 00 340 00000000 0 0 0 0000001a 0 00000000 3
00000120 01 1 05 00 00 7c0 12345678 1 2 0 00000000 1 00000800 3
00000124 01 2 00 00 00 341 00000000 0 0 0 00000120 0 00000000 3
00000128 01 4 05 00 34 680 00000000 1 2 0 00000000 1 00000800 3
0000012c 01 2 00 00 00 341 00000000 0 0 0 00000128 0 00000000 3
00000130 01 0 00 00 00 000 00000000 1 2 0 00000000 1 00000800 3
00000134 01 2 00 00 00 341 00000000 0 0 0 00000130 0 00000000 3
00000138 00 0 00 02 08 102 00000000 1 2 0 00000000 1 00000800 3
0000013c 01 2 00 00 00 341 00000000 0 0 0 00000138 0 00000000 3
00000140 01 2 00 00 00 342 00000000 0 0 0 00000002 0 00000000 3
00000144 00 0 00 00 00 000 00000000 1 b 0 00000000 1 00000800 3
00000148 01 2 00 00 00 342 00000000 0 0 0 0000000b 0 00000000 3
0000014c 00 0 00 01 00 001 00000000 1 3 0 00000000 1 00000800 3
00000150 01 2 00 00 00 342 00000000 0 0 0 00000003 0 00000000 3
00000154 01 1 05 00 00 300 00000080 0 0 0 00001800 0 00000000 3
00000158 01 1 05 00 00 341 00000400 0 0 0 0000014c 0 00000000 3
0000015c 00 0 00 02 18 302 00000000 0 0 1 00000000 1 00000400 0
00000400 00 0 00 00 00 000 00000000 1 8 0 00000000 1 00000800 3
00000800 01 2 00 00 00 342 00000000 0 0 0 00000008 0 00000000 3
00000804 01 2 00 00 00 300 00000000 0 0 0 00000080 0 00000000 3
00000808 00 0 00 02 18 302 00000000 0 0 1 00000000 1 00000400 0
00000400 01 2 00 00 00 340 00000000 1 2 0 00000000 1 00000800 3
00000800 00 0 00 02 18 302 00000000 0 0 1 00000000 1 00000400 0
00000400 00 0 00 02 18 302 00000000 1 2 0 00000000 1 00000800 3
00000800 01 2 00 00 00 300 00000000 0 0 0 00000080 0 00000000 3
00000804 01 2 00 00 00 341 00000000 0 0 0 00000400 0 00000000 3
00000808 01 1 05 00 00 300 00001880 0 0 0 00000080 0 00000000 3
0000080c 01 1 05 00 00 341 00000500 0 0 0 00000400 0 00000000 3
00000810 00 0 00 02 18 302 00000000 0 0 1 00000000 1 00000500 3
00000500 01 2 00 00 00 300 00000000 0 0 0 00001888 0 00000000 3
00000504 00 0 00 05 08 105 00000000 0 0 0 00000000 0 00000000 3
00000508 00 0 00 00 09 120 00000000 0 0 0 00000000 0 00000000 3

// ==== tb.f ====
hw/sys_pkg.sv
hw/exec_system.sv
hw/csr_file.sv
hw/trap_commit.sv
hw/system_unit.sv
verif/system_unit_props.sv
verif/system_unit_tb.sv
